// File: src/spdif_consts.svh
`ifndef SPDIF_CONSTS_SVH
`define SPDIF_CONSTS_SVH

// sampling clocks per bit cell (a power of two of at least 8)
`define SPDIF_CLK_PER_BIT 8

// one and a half bit cells at one level, seen only inside a preamble
`define SPDIF_SAMELVL_SYNC (3 * `SPDIF_CLK_PER_BIT / 2)

// preamble codes in the subbit history at the classify slot
// bit 5 holds the last subbit of the long run, bit 0 the last preamble subbit
// the inverted codes are legal as well
`define SPDIF_PRE_B 6'b010111
`define SPDIF_PRE_W 6'b011011
`define SPDIF_PRE_M 6'b011101

// subframes per user / channel status block
`define SPDIF_BLOCK_LEN 192

// slot numbers count subbits from the end of the preamble run
`define SPDIF_PRE_SLOT 5

// slots 4..27 are decoded into one word, first received bit in the msb
`define SPDIF_AUDIO_SLOT 54

// first subbit of the next preamble, V U C P of the old subframe are decoded
`define SPDIF_UC_SLOT 62

`endif

// File: src/spdif_pkg.sv
`include "spdif_consts.svh"

package spdif_pkg;

	// payload widths
	typedef logic [23:0] audio_word_t;
	typedef logic [`SPDIF_BLOCK_LEN-1:0] block_bits_t;

	// last six recovered subbits, newest in bit 0
	typedef logic [5:0] subbit_hist_t;

	// subbit position in a subframe, wraps once per subframe
	typedef logic [5:0] slot_cnt_t;

	typedef enum logic [1:0] {
		PRE_NONE,
		PRE_B,
		PRE_M,
		PRE_W
	} pre_kind_e;

	typedef enum logic [1:0] {
		SYNC_HUNT,
		SYNC_ALIGN,
		SYNC_LOCKED
	} sync_state_e;

	// bit recovery outputs, the strobes are one clock wide
	typedef struct packed {
		logic         subbit_ready;
		logic         fullbit_ready;  // second half of a bit cell just landed
		logic         samelvl_sync;
		slot_cnt_t    slot;
		subbit_hist_t hist;
		logic         line_lvl;       // registered line sample
	} subbit_strobe_t;

endpackage

// File: src/spdif_bit_recovery.sv
`timescale 1ns/100ps
`include "spdif_consts.svh"

module spdif_bit_recovery
	import spdif_pkg::*;
(
	input  logic           clk,
	input  logic           clk_counter_rst,
	input  logic           signal_i,
	input  logic           align_rst_i,
	output subbit_strobe_t rec_o
);

	localparam int SUB_CLKS = `SPDIF_CLK_PER_BIT / 2;  // samples per subbit
	localparam int CELL_W = $clog2(SUB_CLKS);
	localparam int ACC_W = $clog2(SUB_CLKS + 1);
	localparam int RUN_MAX = `SPDIF_SAMELVL_SYNC + 1;
	localparam int RUN_W = $clog2(RUN_MAX + 1);

	logic line_lvl;
	logic [RUN_W-1:0] run_cnt;
	logic samelvl_sync;

	logic [CELL_W-1:0] cell_cnt;
	logic [ACC_W-1:0] high_cnt;
	logic cell_end;
	logic subbit;

	subbit_hist_t hist;
	slot_cnt_t slot;
	logic subbit_ready;
	logic fullbit_ready;

	// run length of the current line level, saturates one past the sync length
	always_ff @(posedge clk) begin
		if (clk_counter_rst) begin
			line_lvl <= 1'b0;
			run_cnt <= '0;
			samelvl_sync <= 1'b0;
		end else begin
			line_lvl <= signal_i;
			if (signal_i != line_lvl)
				run_cnt <= RUN_W'(1);
			else if (run_cnt != RUN_W'(RUN_MAX))
				run_cnt <= run_cnt + 1'b1;
			samelvl_sync <= (run_cnt == RUN_W'(`SPDIF_SAMELVL_SYNC));
		end
	end

	assign cell_end = (cell_cnt == CELL_W'(SUB_CLKS - 1));
	assign subbit = (high_cnt >= ACC_W'(SUB_CLKS / 2));  // majority, ties go high

	// a sync pulse lands on a cell boundary, so the cell restarts there
	always_ff @(posedge clk) begin
		if (clk_counter_rst || align_rst_i || samelvl_sync || cell_end)
			cell_cnt <= '0;
		else
			cell_cnt <= cell_cnt + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (align_rst_i || samelvl_sync || cell_end)
			high_cnt <= ACC_W'(line_lvl);  // first sample of the next cell
		else
			high_cnt <= high_cnt + ACC_W'(line_lvl);
	end

	always_ff @(posedge clk) begin
		if (cell_end)
			hist <= {hist[4:0], subbit};
	end

	// slot and strobes line up with the history update
	always_ff @(posedge clk) begin
		if (clk_counter_rst) begin
			slot <= '0;
			subbit_ready <= 1'b0;
			fullbit_ready <= 1'b0;
		end else begin
			subbit_ready <= cell_end && !align_rst_i;
			fullbit_ready <= cell_end && !align_rst_i && !slot[0];  // next slot is odd
			if (align_rst_i)
				slot <= '0;
			else if (cell_end)
				slot <= slot + 1'b1;
		end
	end

	assign rec_o = '{
		subbit_ready:  subbit_ready,
		fullbit_ready: fullbit_ready,
		samelvl_sync:  samelvl_sync,
		slot:          slot,
		hist:          hist,
		line_lvl:      line_lvl
	};

endmodule

// File: src/spdif_frame_sync.sv
`timescale 1ns/100ps
`include "spdif_consts.svh"

module spdif_frame_sync
	import spdif_pkg::*;
(
	input  logic           clk,
	input  logic           clk_counter_rst,
	input  subbit_strobe_t rec_i,
	output logic           align_rst_o,
	output logic           block_start_o,
	output logic           locked_o,
	output logic           lrck_o
);

	sync_state_e state;
	pre_kind_e kind;
	subbit_hist_t code;
	logic code_ready;
	logic code_ok;
	logic align_lvl;

	// while hunting the run never enters the history, so on first alignment
	// its level is the inverse of the sample taken at the sync pulse
	assign code = (state == SYNC_ALIGN) ? {~align_lvl, rec_i.hist[4:0]} : rec_i.hist;

	// preamble class from the six subbits after the long run
	always_comb begin
		case (code)
			`SPDIF_PRE_B, ~`SPDIF_PRE_B: kind = PRE_B;
			`SPDIF_PRE_M, ~`SPDIF_PRE_M: kind = PRE_M;
			`SPDIF_PRE_W, ~`SPDIF_PRE_W: kind = PRE_W;
			default: kind = PRE_NONE;
		endcase
	end

	assign code_ready = rec_i.subbit_ready && (rec_i.slot == slot_cnt_t'(`SPDIF_PRE_SLOT));

	// on first alignment the subbit after the run has to match the raw
	// line level sampled at the sync pulse
	always_comb begin
		code_ok = (kind != PRE_NONE);
		if (state == SYNC_ALIGN && rec_i.hist[4] != align_lvl)
			code_ok = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (clk_counter_rst) begin
			state <= SYNC_HUNT;
			align_rst_o <= 1'b1;
			block_start_o <= 1'b0;
			locked_o <= 1'b0;
			lrck_o <= 1'b0;
			align_lvl <= 1'b0;
		end else begin
			block_start_o <= 1'b0;
			case (state)
				SYNC_HUNT: begin
					// counters stay at zero until a preamble run shows up
					if (rec_i.samelvl_sync) begin
						state <= SYNC_ALIGN;
						align_rst_o <= 1'b0;
						align_lvl <= rec_i.line_lvl;
					end
				end
				SYNC_ALIGN, SYNC_LOCKED: begin
					if (code_ready) begin
						if (code_ok) begin
							state <= SYNC_LOCKED;
							locked_o <= 1'b1;
							lrck_o <= (kind == PRE_W);  // right channel on W only
							block_start_o <= (kind == PRE_B);
						end else begin
							state <= SYNC_HUNT;
							locked_o <= 1'b0;
							align_rst_o <= 1'b1;
						end
					end
				end
				default: begin
					state <= SYNC_HUNT;
					align_rst_o <= 1'b1;
				end
			endcase
		end
	end

endmodule

// File: src/spdif_subframe_capture.sv
`timescale 1ns/100ps
`include "spdif_consts.svh"

module spdif_subframe_capture
	import spdif_pkg::*;
(
	input  logic           clk,
	input  logic           clk_counter_rst,
	input  subbit_strobe_t rec_i,
	input  logic           block_start_i,
	output audio_word_t    data_o,
	output logic           ack_o,
	output block_bits_t    udata_o,
	output block_bits_t    cdata_o
);

	localparam int BLK_W = $bits(block_bits_t);

	logic bmc_bit;
	audio_word_t bit_hist;
	logic word_ready;
	logic uc_ready;
	block_bits_t u_shift;
	block_bits_t c_shift;

	// hist[2] is the end of the previous bit, hist[1:0] the current bit
	always_comb begin
		case (rec_i.hist[2:0])
			3'b010, 3'b101: bmc_bit = 1'b1;  // mid cell transition
			3'b011, 3'b100: bmc_bit = 1'b0;
			default: bmc_bit = 1'b0;  // boundary transition missing
		endcase
	end

	// last 24 decoded bits, newest in bit 0
	always_ff @(posedge clk) begin
		if (rec_i.fullbit_ready)
			bit_hist <= {bit_hist[22:0], bmc_bit};
	end

	assign word_ready = rec_i.subbit_ready &&
		(rec_i.slot == slot_cnt_t'(`SPDIF_AUDIO_SLOT));
	assign uc_ready = rec_i.subbit_ready &&
		(rec_i.slot == slot_cnt_t'(`SPDIF_UC_SLOT));

	// the last audio bit was shifted in at the slot before
	always_ff @(posedge clk) begin
		if (clk_counter_rst) begin
			ack_o <= 1'b0;
			data_o <= '0;
		end else begin
			ack_o <= word_ready;
			if (word_ready)
				data_o <= bit_hist;
		end
	end

	// bit_hist[3:0] holds V U C P of the subframe that just ended
	always_ff @(posedge clk) begin
		if (uc_ready) begin
			u_shift <= {u_shift[BLK_W-2:0], bit_hist[2]};
			c_shift <= {c_shift[BLK_W-2:0], bit_hist[1]};
		end
	end

	// B preamble hands over the finished block, oldest subframe in the msb
	always_ff @(posedge clk) begin
		if (block_start_i) begin
			udata_o <= u_shift;
			cdata_o <= c_shift;
		end
	end

endmodule

// File: src/spdif_rx_top.sv
`timescale 1ns/100ps

module spdif_rx_top
	import spdif_pkg::*;
(
	input  logic        clk,
	input  logic        clk_counter_rst,
	input  logic        signal_i,
	output audio_word_t data_o,
	output logic        ack_o,
	output logic        locked_o,
	output logic        lrck_o,
	output block_bits_t udata_o,
	output block_bits_t cdata_o
);

	subbit_strobe_t rec;
	logic align_rst;    // holds the cell and slot counters while hunting
	logic block_start;

	spdif_bit_recovery u_recovery (
		.clk             (clk),
		.clk_counter_rst (clk_counter_rst),
		.signal_i        (signal_i),
		.align_rst_i     (align_rst),
		.rec_o           (rec)
	);

	spdif_frame_sync u_sync (
		.clk             (clk),
		.clk_counter_rst (clk_counter_rst),
		.rec_i           (rec),
		.align_rst_o     (align_rst),
		.block_start_o   (block_start),
		.locked_o        (locked_o),
		.lrck_o          (lrck_o)
	);

	spdif_subframe_capture u_capture (
		.clk             (clk),
		.clk_counter_rst (clk_counter_rst),
		.rec_i           (rec),
		.block_start_i   (block_start),
		.data_o          (data_o),
		.ack_o           (ack_o),
		.udata_o         (udata_o),
		.cdata_o         (cdata_o)
	);

endmodule

// File: verification/spdif_tx_model.sv
`timescale 1ns/100ps
`include "spdif_consts.svh"

module spdif_tx_model
	import spdif_pkg::*;
(
	input  logic clk,
	output logic signal_o
);

	localparam int SUB_CLKS = `SPDIF_CLK_PER_BIT / 2;

	// preamble subbits, first one always flips the line
	localparam logic [7:0] PAT_B = 8'b11101000;
	localparam logic [7:0] PAT_M = 8'b11100010;
	localparam logic [7:0] PAT_W = 8'b11100100;
	localparam logic [7:0] PAT_BAD = 8'b11110000;  // long run but no legal code

	logic level;

	initial begin
		signal_o = 1'b0;
		level = 1'b0;
	end

	task automatic send_subbit(input logic b);
		for (int i = 0; i < SUB_CLKS; i++) begin
			@(negedge clk);
			signal_o = b;
		end
		level = b;
	endtask

	// quiet line, then one high subbit so the first preamble run sits low
	task automatic lead_in();
		for (int i = 0; i < 16; i++)
			send_subbit(1'b0);
		send_subbit(1'b1);
	endtask

	task automatic send_subframe(
		input audio_word_t word,
		input logic        u,
		input logic        c,
		input logic        bad,
		input pre_kind_e   kind
	);
		logic [7:0] pat;
		logic start;
		logic par;
		logic [27:0] bits;
		case (kind)
			PRE_B:   pat = PAT_B;
			PRE_M:   pat = PAT_M;
			default: pat = PAT_W;
		endcase
		if (bad)
			pat = PAT_BAD;
		start = level;
		for (int j = 7; j >= 0; j--)
			send_subbit(pat[j] ? ~start : start);
		par = ^{word, 1'b0, u, c};  // even parity over the data slots
		bits = {word, 1'b0, u, c, par};  // word msb first, then V U C P
		for (int k = 27; k >= 0; k--) begin
			send_subbit(~level);
			send_subbit(bits[k] ? ~level : level);  // mid cell flip for a one
		end
	endtask

endmodule

// File: verification/spdif_asserts.sv
`timescale 1ns/100ps

module spdif_asserts
	import spdif_pkg::*;
(
	input logic        clk,
	input logic        clk_counter_rst,
	input logic        ack_o,
	input logic        locked_o,
	input audio_word_t data_o
);

	single_ack: assert property (@(posedge clk) disable iff (clk_counter_rst)
		ack_o |=> !ack_o)
		else $error("ack_o high for two cycles in a row");

	data_hold: assert property (@(posedge clk) disable iff (clk_counter_rst)
		!$stable(data_o) |-> $rose(ack_o))
		else $error("data_o changed without an ack_o");

	ack_needs_lock: assert property (@(posedge clk) disable iff (clk_counter_rst)
		ack_o |-> locked_o)
		else $error("ack_o high while not locked");

endmodule

bind spdif_rx_top spdif_asserts u_asserts (
	.clk             (clk),
	.clk_counter_rst (clk_counter_rst),
	.ack_o           (ack_o),
	.locked_o        (locked_o),
	.data_o          (data_o)
);

// File: verification/spdif_tb.sv
`timescale 1ns/100ps
`include "spdif_consts.svh"

module spdif_tb
	import spdif_pkg::*;
();

	localparam int BLOCK = `SPDIF_BLOCK_LEN;
	localparam int NROWS = 2 * BLOCK + 24;
	localparam int BAD_ROW = 2 * BLOCK + 12;
	localparam int ACK_TIMEOUT = 4000;
	localparam logic [0:7][23:0] FIXED = {24'h000000, 24'hffffff, 24'h800001,
		24'h555555, 24'haaaaaa, 24'h123456, 24'h7fffff, 24'hfedcba};

	logic clk;
	logic clk_counter_rst;
	logic signal_i;
	audio_word_t data_o;
	logic ack_o;
	logic locked_o;
	logic lrck_o;
	block_bits_t udata_o;
	block_bits_t cdata_o;

	audio_word_t word_tab[NROWS];
	logic u_tab[NROWS];
	logic c_tab[NROWS];
	logic bad_tab[NROWS];
	int exp_rows[$];  // rows that should produce an ack, in order
	int ack_idx = 0;
	int data_errs = 0;
	int lock_errs = 0;
	int timeout_errs = 0;
	int lock_falls = 0;
	logic locked_q = 1'b0;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	spdif_rx_top u_dut (
		.clk             (clk),
		.clk_counter_rst (clk_counter_rst),
		.signal_i        (signal_i),
		.data_o          (data_o),
		.ack_o           (ack_o),
		.locked_o        (locked_o),
		.lrck_o          (lrck_o),
		.udata_o         (udata_o),
		.cdata_o         (cdata_o)
	);

	spdif_tx_model u_tx (
		.clk      (clk),
		.signal_o (signal_i)
	);

	function automatic pre_kind_e frame_kind(input int row);
		if (row % BLOCK == 0)
			return PRE_B;
		return (row % 2 == 0) ? PRE_M : PRE_W;
	endfunction

	task automatic fill_table();
		for (int row = 0; row < NROWS; row++) begin
			word_tab[row] = (row < 8) ? FIXED[row] : audio_word_t'($urandom);
			u_tab[row] = $urandom % 2;
			c_tab[row] = $urandom % 2;
			bad_tab[row] = (row == BAD_ROW);
			if (row != BAD_ROW)
				exp_rows.push_back(row);
		end
	endtask

	// block ending before a B preamble, its first subframe in the msb
	task automatic check_block(input int row);
		block_bits_t exp_u;
		block_bits_t exp_c;
		int base;
		base = row - BLOCK;
		for (int i = 0; i < BLOCK; i++) begin
			exp_u[BLOCK-1-i] = u_tab[base+i];
			exp_c[BLOCK-1-i] = c_tab[base+i];
		end
		assert (udata_o == exp_u) else begin
			data_errs++;
			$display("ERROR %0t: udata_o wrong for the block before row %0d", $time, row);
		end
		assert (cdata_o == exp_c) else begin
			data_errs++;
			$display("ERROR %0t: cdata_o wrong for the block before row %0d", $time, row);
		end
	endtask

	task automatic check_ack();
		int row;
		assert (ack_idx < exp_rows.size()) else begin
			data_errs++;
			$display("ERROR %0t: ack_o with no table row left", $time);
		end
		if (ack_idx < exp_rows.size()) begin
			row = exp_rows[ack_idx];
			assert (data_o == word_tab[row]) else begin
				data_errs++;
				$display("ERROR %0t: row %0d data_o %h expected %h",
					$time, row, data_o, word_tab[row]);
			end
			assert (lrck_o == (row % 2 == 1)) else begin
				data_errs++;
				$display("ERROR %0t: row %0d lrck_o %b", $time, row, lrck_o);
			end
			if (row != 0 && row % BLOCK == 0)
				check_block(row);
			ack_idx++;
		end
	endtask

	// outputs are registered, so the falling edge sees them settled
	always @(negedge clk) begin
		if (!clk_counter_rst) begin
			if (locked_q && !locked_o)
				lock_falls++;
			locked_q = locked_o;
			if (ack_o)
				check_ack();
		end
	end

	initial begin
		int waited;
		clk_counter_rst = 1'b1;
		void'($urandom(32'h238fa22e));
		fill_table();
		repeat (2) @(negedge clk);
		clk_counter_rst = 1'b0;
		@(negedge clk);
		assert (!ack_o && !locked_o) else begin
			lock_errs++;
			$display("ERROR %0t: ack_o or locked_o high after reset", $time);
		end
		u_tx.lead_in();
		assert (!locked_o) else begin
			lock_errs++;
			$display("ERROR %0t: locked_o high before any preamble", $time);
		end
		for (int row = 0; row < NROWS; row++) begin
			u_tx.send_subframe(word_tab[row], u_tab[row], c_tab[row], bad_tab[row],
				frame_kind(row));
			assert (locked_o == !bad_tab[row]) else begin
				lock_errs++;
				$display("ERROR %0t: row %0d locked_o %b", $time, row, locked_o);
			end
		end
		waited = 0;
		while (ack_idx < exp_rows.size() && waited < ACK_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (ack_idx < exp_rows.size()) begin
			timeout_errs++;
			$display("timeout: only %0d of %0d audio words arrived", ack_idx, exp_rows.size());
		end
		assert (lock_falls == 1) else begin
			lock_errs++;
			$display("ERROR %0t: locked_o fell %0d times, expected once", $time, lock_falls);
		end
		$display("errors: %0d data, %0d lock, %0d timeout", data_errs, lock_errs, timeout_errs);
		if (data_errs + lock_errs + timeout_errs == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+src
src/spdif_pkg.sv
src/spdif_bit_recovery.sv
src/spdif_frame_sync.sv
src/spdif_subframe_capture.sv
src/spdif_rx_top.sv
verification/spdif_tx_model.sv
verification/spdif_asserts.sv
verification/spdif_tb.sv
